// File: source/grid_pkg.sv
package grid_pkg;

	////////////////////////////////////////////////////////////
	// Shared types
	////////////////////////////////////////////////////////////

	// Raster coordinate, wide enough for 640 and beyond
	typedef logic [9:0] pos_t;
	// Cell column or row index
	typedef logic [3:0] cell_idx_t;
	// Cell status code
	typedef logic [4:0] cell_status_t;
	// Colour, 4 bits each of red, green, blue
	typedef logic [11:0] rgb_t;

	////////////////////////////////////////////////////////////
	// Board geometry
	////////////////////////////////////////////////////////////

	localparam int GRID_CELLS  = 10;
	localparam int CELL_WIDTH  = 64;
	localparam int CELL_HEIGHT = 48;
	localparam int LINE_WIDTH  = 2;
	localparam int NUM_CELLS   = GRID_CELLS * GRID_CELLS;
	// Board extent in pixels, 640 by 480
	localparam int GRID_WIDTH  = GRID_CELLS * CELL_WIDTH;
	localparam int GRID_HEIGHT = GRID_CELLS * CELL_HEIGHT;

	// Status cycle order
	localparam cell_status_t ST_FREE       = 5'd0;
	localparam cell_status_t ST_OCCUPIED   = 5'd1;
	localparam cell_status_t ST_PLAYER_HIT = 5'd2;
	localparam cell_status_t ST_AI_HIT     = 5'd3;
	localparam cell_status_t ST_BOTH_HIT   = 5'd4;

	////////////////////////////////////////////////////////////
	// Palette
	////////////////////////////////////////////////////////////

	// Blue-grey sea
	localparam rgb_t COL_BACKGROUND = 12'h56D;
	// Magenta grid lines
	localparam rgb_t COL_LINE       = 12'hF0F;
	localparam rgb_t COL_SHIP       = 12'h555;
	localparam rgb_t COL_PLAYER_HIT = 12'hF00;
	localparam rgb_t COL_AI_HIT     = 12'h00F;
	localparam rgb_t COL_BOTH_HIT   = 12'hFF0;
	localparam rgb_t COL_OUTSIDE    = 12'h000;

	// Engine FSM states
	typedef enum logic [1:0]
	{
		INIT_CLEAR,
		PLAYER_IDLE,
		PLAYER_READ,
		PLAYER_WRITE
	} engine_state_t;

endpackage

// File: source/cell_loc_if.sv
`timescale 1ns/1ps

// One located cell, from a locator to the store and one consumer
interface cell_loc_if;

	// Cell coordinates, always a valid index
	grid_pkg::cell_idx_t cell_x;
	grid_pkg::cell_idx_t cell_y;
	// Pixel sits on a grid line
	logic on_line;
	// Pixel lies inside the 640 by 480 board
	logic in_grid;

	modport source (
		output cell_x, cell_y, on_line, in_grid
	);

	modport sink (
		input cell_x, cell_y, on_line, in_grid
	);

endinterface

// File: source/cell_wr_if.sv
`timescale 1ns/1ps

// Single write port, engine into cell store
interface cell_wr_if;

	grid_pkg::cell_idx_t wr_x;
	grid_pkg::cell_idx_t wr_y;
	// One-cycle write strobe
	logic we;
	// New status for the addressed cell
	grid_pkg::cell_status_t wr_status;

	modport source (
		output wr_x, wr_y, we, wr_status
	);

	modport sink (
		input wr_x, wr_y, we, wr_status
	);

endinterface

// File: source/cell_locator.sv
`timescale 1ns/1ps

module cell_locator (
	input  logic           clk_in,
	input  logic           rst_n,
	input  grid_pkg::pos_t pos_x,
	input  grid_pkg::pos_t pos_y,
	cell_loc_if.source     loc
);

	// Combinational split of each coordinate
	grid_pkg::cell_idx_t col;
	grid_pkg::cell_idx_t row;
	grid_pkg::pos_t      rem_x;
	grid_pkg::pos_t      rem_y;

	////////////////////////////////////////////////////////////
	// Count off whole cells
	////////////////////////////////////////////////////////////

	// Stops at the last column, so the index stays in range
	// even for positions beyond the board
	always_comb
	begin
		col   = '0;
		row   = '0;
		rem_x = pos_x;
		rem_y = pos_y;
		for (int i = 0; i < grid_pkg::GRID_CELLS - 1; i++)
		begin
			if (rem_x >= grid_pkg::pos_t'(grid_pkg::CELL_WIDTH))
			begin
				rem_x = rem_x - grid_pkg::pos_t'(grid_pkg::CELL_WIDTH);
				col   = col + 1'b1;
			end
			if (rem_y >= grid_pkg::pos_t'(grid_pkg::CELL_HEIGHT))
			begin
				rem_y = rem_y - grid_pkg::pos_t'(grid_pkg::CELL_HEIGHT);
				row   = row + 1'b1;
			end
		end
	end

	// One register stage for every field
	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			loc.cell_x  <= '0;
			loc.cell_y  <= '0;
			loc.on_line <= 1'b0;
			loc.in_grid <= 1'b0;
		end
		else
		begin
			loc.cell_x  <= col;
			loc.cell_y  <= row;
			// Line band at the left and top edge of each cell
			loc.on_line <= (rem_x < grid_pkg::pos_t'(grid_pkg::LINE_WIDTH))
				|| (rem_y < grid_pkg::pos_t'(grid_pkg::LINE_WIDTH));
			loc.in_grid <= (pos_x < grid_pkg::pos_t'(grid_pkg::GRID_WIDTH))
				&& (pos_y < grid_pkg::pos_t'(grid_pkg::GRID_HEIGHT));
		end
	end

endmodule

// File: source/cell_store.sv
`timescale 1ns/1ps

module cell_store (
	input  logic                   clk_in,
	input  logic                   rst_n,
	cell_loc_if.sink               rd_a,
	cell_loc_if.sink               rd_b,
	cell_wr_if.sink                wr,
	output grid_pkg::cell_status_t status_a,
	output grid_pkg::cell_status_t status_b
);

	// Board contents, row major
	grid_pkg::cell_status_t mem [grid_pkg::NUM_CELLS];

	// Row and column to flat address
	function automatic int cell_addr(
		input grid_pkg::cell_idx_t x,
		input grid_pkg::cell_idx_t y
	);
		return int'(y) * grid_pkg::GRID_CELLS + int'(x);
	endfunction

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in)
	begin
		if (wr.we)
		begin
			mem[cell_addr(wr.wr_x, wr.wr_y)] <= wr.wr_status;
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////

	// Old data on a same-edge collision, new data one edge later
	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			status_a <= grid_pkg::ST_FREE;
			status_b <= grid_pkg::ST_FREE;
		end
		else
		begin
			// Port A follows the mouse
			status_a <= mem[cell_addr(rd_a.cell_x, rd_a.cell_y)];
			// Port B follows the raster
			status_b <= mem[cell_addr(rd_b.cell_x, rd_b.cell_y)];
		end
	end

	// Engine must never address past the board
	a_wr_in_range: assert property (@(posedge clk_in) disable iff (!rst_n)
		wr.we |-> (wr.wr_x < grid_pkg::GRID_CELLS) && (wr.wr_y < grid_pkg::GRID_CELLS));

endmodule

// File: source/grid_engine.sv
`timescale 1ns/1ps

module grid_engine (
	input  logic                   clk_in,
	input  logic                   rst_n,
	input  logic                   mouse_click,
	cell_loc_if.sink               mouse,
	input  grid_pkg::cell_status_t mouse_status,
	cell_wr_if.source              wr,
	output logic                   ready
);

	grid_pkg::engine_state_t state;
	// Button history for edge detect
	logic click_d;
	logic click_rise;
	// Clear sweep position
	grid_pkg::cell_idx_t clr_x;
	grid_pkg::cell_idx_t clr_y;
	logic clr_last;

	// Fixed status cycle, unknown codes fall back to free
	function automatic grid_pkg::cell_status_t next_status(
		input grid_pkg::cell_status_t cur
	);
		case (cur)
			grid_pkg::ST_FREE:       return grid_pkg::ST_OCCUPIED;
			grid_pkg::ST_OCCUPIED:   return grid_pkg::ST_PLAYER_HIT;
			grid_pkg::ST_PLAYER_HIT: return grid_pkg::ST_AI_HIT;
			grid_pkg::ST_AI_HIT:     return grid_pkg::ST_BOTH_HIT;
			default:                 return grid_pkg::ST_FREE;
		endcase
	endfunction

	// Held button gives a single rise
	assign click_rise = mouse_click & ~click_d;
	assign clr_last = (clr_x == grid_pkg::cell_idx_t'(grid_pkg::GRID_CELLS - 1))
		&& (clr_y == grid_pkg::cell_idx_t'(grid_pkg::GRID_CELLS - 1));

	// Read data from the store lands in the write cycle
	assign wr.wr_status = (state == grid_pkg::PLAYER_WRITE) ? next_status(mouse_status)
		: grid_pkg::ST_FREE;

	////////////////////////////////////////////////////////////
	// Turn FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= grid_pkg::INIT_CLEAR;
			click_d <= 1'b0;
			clr_x   <= '0;
			clr_y   <= '0;
			wr.we   <= 1'b0;
			ready   <= 1'b0;
		end
		else
		begin
			click_d <= mouse_click;
			case (state)
				grid_pkg::INIT_CLEAR:
				begin
					// One free write per cycle, row by row
					wr.we <= 1'b1;
					if (clr_x == grid_pkg::cell_idx_t'(grid_pkg::GRID_CELLS - 1))
					begin
						clr_x <= '0;
						clr_y <= clr_y + 1'b1;
					end
					else
					begin
						clr_x <= clr_x + 1'b1;
					end
					if (clr_last)
					begin
						state <= grid_pkg::PLAYER_IDLE;
					end
				end
				grid_pkg::PLAYER_IDLE:
				begin
					// Last clear write lands here
					wr.we <= 1'b0;
					ready <= 1'b1;
					if (ready && click_rise)
					begin
						state <= grid_pkg::PLAYER_READ;
					end
				end
				grid_pkg::PLAYER_READ:
				begin
					// Locator now holds the clicked cell
					if (mouse.in_grid)
					begin
						wr.we <= 1'b1;
						state <= grid_pkg::PLAYER_WRITE;
					end
					else
					begin
						state <= grid_pkg::PLAYER_IDLE;
					end
				end
				grid_pkg::PLAYER_WRITE:
				begin
					wr.we <= 1'b0;
					state <= grid_pkg::PLAYER_IDLE;
				end
				default:
				begin
					wr.we <= 1'b0;
					state <= grid_pkg::INIT_CLEAR;
				end
			endcase
		end
	end

	// Write address, sweep counter or latched mouse cell
	always_ff @(posedge clk_in)
	begin
		if (state == grid_pkg::INIT_CLEAR)
		begin
			wr.wr_x <= clr_x;
			wr.wr_y <= clr_y;
		end
		else if (state == grid_pkg::PLAYER_READ)
		begin
			wr.wr_x <= mouse.cell_x;
			wr.wr_y <= mouse.cell_y;
		end
	end

	// Click writes are single pulses
	a_we_pulse: assert property (@(posedge clk_in) disable iff (!rst_n)
		(wr.we && state != grid_pkg::INIT_CLEAR) |=> !wr.we);

	// Board stays usable once cleared
	a_ready_sticky: assert property (@(posedge clk_in) disable iff (!rst_n)
		ready |=> ready);

endmodule

// File: source/grid_renderer.sv
`timescale 1ns/1ps

module grid_renderer (
	input  logic                   clk_in,
	input  logic                   rst_n,
	cell_loc_if.sink               pixel,
	input  grid_pkg::cell_status_t cell_status,
	output grid_pkg::rgb_t         pixel_rgb
);

	// Flags aligned with the store read
	logic line_d;
	logic in_grid_d;

	// Status to palette entry
	function automatic grid_pkg::rgb_t status_colour(
		input grid_pkg::cell_status_t st
	);
		case (st)
			grid_pkg::ST_OCCUPIED:   return grid_pkg::COL_SHIP;
			grid_pkg::ST_PLAYER_HIT: return grid_pkg::COL_PLAYER_HIT;
			grid_pkg::ST_AI_HIT:     return grid_pkg::COL_AI_HIT;
			grid_pkg::ST_BOTH_HIT:   return grid_pkg::COL_BOTH_HIT;
			// Free water, unknown codes too
			default:                 return grid_pkg::COL_BACKGROUND;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Pixel pipeline, stages two and three
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			line_d    <= 1'b0;
			in_grid_d <= 1'b0;
			pixel_rgb <= grid_pkg::COL_OUTSIDE;
		end
		else
		begin
			line_d    <= pixel.on_line;
			in_grid_d <= pixel.in_grid;
			// Outside wins over line, line over cell fill
			if (!in_grid_d)
			begin
				pixel_rgb <= grid_pkg::COL_OUTSIDE;
			end
			else if (line_d)
			begin
				pixel_rgb <= grid_pkg::COL_LINE;
			end
			else
			begin
				pixel_rgb <= status_colour(cell_status);
			end
		end
	end

endmodule

// File: source/grid_top.sv
`timescale 1ns/1ps

module grid_top (
	input  logic                   clk_in,
	input  logic                   rst_n,
	input  grid_pkg::pos_t         mouse_pos_x,
	input  grid_pkg::pos_t         mouse_pos_y,
	input  grid_pkg::pos_t         pos_x,
	input  grid_pkg::pos_t         pos_y,
	input  logic                   mouse_click,
	output grid_pkg::rgb_t         pixel_rgb,
	output grid_pkg::cell_status_t pointer_status,
	output logic                   ready
);

	// Located mouse and raster cells
	cell_loc_if mouse_loc ();
	cell_loc_if pixel_loc ();
	// Engine write port
	cell_wr_if  cell_wr ();

	// Status under the mouse, read port A
	grid_pkg::cell_status_t mouse_status;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	cell_locator u_mouse_locator (
		.clk_in (clk_in),
		.rst_n  (rst_n),
		.pos_x  (mouse_pos_x),
		.pos_y  (mouse_pos_y),
		.loc    (mouse_loc)
	);

	cell_locator u_pixel_locator (
		.clk_in (clk_in),
		.rst_n  (rst_n),
		.pos_x  (pos_x),
		.pos_y  (pos_y),
		.loc    (pixel_loc)
	);

	// Board memory, raster port doubles as pointer status
	cell_store u_cell_store (
		.clk_in   (clk_in),
		.rst_n    (rst_n),
		.rd_a     (mouse_loc),
		.rd_b     (pixel_loc),
		.wr       (cell_wr),
		.status_a (mouse_status),
		.status_b (pointer_status)
	);

	// Execute
	grid_engine u_grid_engine (
		.clk_in       (clk_in),
		.rst_n        (rst_n),
		.mouse_click  (mouse_click),
		.mouse        (mouse_loc),
		.mouse_status (mouse_status),
		.wr           (cell_wr),
		.ready        (ready)
	);

	// Result
	grid_renderer u_grid_renderer (
		.clk_in      (clk_in),
		.rst_n       (rst_n),
		.pixel       (pixel_loc),
		.cell_status (pointer_status),
		.pixel_rgb   (pixel_rgb)
	);

endmodule

// File: tb/grid_tb.sv
`timescale 1ns/1ps

module grid_tb;

	// Test sizes
	localparam int HOLD_MAX       = 4;
	localparam int WRAP_CLICKS    = 5;
	localparam int RAND_CLICKS    = 30;
	localparam int OUTSIDE_CLICKS = 8;
	localparam int HELD_CYCLES    = 20;
	localparam int EDGE_PIXELS    = 80;
	localparam int STREAM_LEN     = 400;
	// Setup, press, longest hold, settle
	localparam int CLICK_CYCLES   = HOLD_MAX + 6;
	// One centre per cell plus pipeline drain
	localparam int SCAN_CYCLES    = grid_pkg::NUM_CELLS + 3;
	// Whole run with a factor two margin
	localparam int TIMEOUT_CYCLES = 2 * (3 + grid_pkg::NUM_CELLS + 10
		+ (WRAP_CLICKS + RAND_CLICKS + OUTSIDE_CLICKS) * (CLICK_CYCLES + 4)
		+ HELD_CYCLES + CLICK_CYCLES + 3 * SCAN_CYCLES
		+ EDGE_PIXELS + 3 + STREAM_LEN + 3);
	// Board extent from cell geometry
	localparam int BOARD_W = grid_pkg::GRID_CELLS * grid_pkg::CELL_WIDTH;
	localparam int BOARD_H = grid_pkg::GRID_CELLS * grid_pkg::CELL_HEIGHT;

	logic                   clk_in;
	logic                   rst_n;
	grid_pkg::pos_t         mouse_pos_x;
	grid_pkg::pos_t         mouse_pos_y;
	grid_pkg::pos_t         pos_x;
	grid_pkg::pos_t         pos_y;
	logic                   mouse_click;
	grid_pkg::rgb_t         pixel_rgb;
	grid_pkg::cell_status_t pointer_status;
	logic                   ready;

	// Board model, row then column
	grid_pkg::cell_status_t board [grid_pkg::GRID_CELLS][grid_pkg::GRID_CELLS];
	// Expected results in flight, index 0 is the newest
	grid_pkg::rgb_t         rgb_pipe [3];
	logic                   rgb_valid [3];
	grid_pkg::cell_status_t st_pipe [2];
	logic                   st_valid [2];

	logic [31:0] lfsr_state = 32'h9de4_462c;
	string       test_name;
	int          rgb_errors;
	int          status_errors;
	int          other_errors;
	int          cycle_count;
	int          clear_cycles;

	grid_top u_grid_top (
		.clk_in         (clk_in),
		.rst_n          (rst_n),
		.mouse_pos_x    (mouse_pos_x),
		.mouse_pos_y    (mouse_pos_y),
		.pos_x          (pos_x),
		.pos_y          (pos_y),
		.mouse_click    (mouse_click),
		.pixel_rgb      (pixel_rgb),
		.pointer_status (pointer_status),
		.ready          (ready)
	);

	// 40 ns period
	always #20 clk_in = ~clk_in;

	////////////////////////////////////////////////////////////
	// Random numbers
	////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	function automatic int rand_below(input int limit);
		return int'(rand_bits(16)) % limit;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Click cycle free, occupied, player hit, AI hit, both hit
	function automatic grid_pkg::cell_status_t advance_status(
		input grid_pkg::cell_status_t st
	);
		if (st == grid_pkg::ST_FREE)
			return grid_pkg::ST_OCCUPIED;
		if (st == grid_pkg::ST_OCCUPIED)
			return grid_pkg::ST_PLAYER_HIT;
		if (st == grid_pkg::ST_PLAYER_HIT)
			return grid_pkg::ST_AI_HIT;
		if (st == grid_pkg::ST_AI_HIT)
			return grid_pkg::ST_BOTH_HIT;
		return grid_pkg::ST_FREE;
	endfunction

	function automatic grid_pkg::rgb_t status_to_colour(
		input grid_pkg::cell_status_t st
	);
		if (st == grid_pkg::ST_OCCUPIED)
			return grid_pkg::COL_SHIP;
		if (st == grid_pkg::ST_PLAYER_HIT)
			return grid_pkg::COL_PLAYER_HIT;
		if (st == grid_pkg::ST_AI_HIT)
			return grid_pkg::COL_AI_HIT;
		if (st == grid_pkg::ST_BOTH_HIT)
			return grid_pkg::COL_BOTH_HIT;
		return grid_pkg::COL_BACKGROUND;
	endfunction

	function automatic logic inside_board(input int x, input int y);
		return (x < BOARD_W) && (y < BOARD_H);
	endfunction

	// Outside first, then line band, then cell fill
	function automatic grid_pkg::rgb_t expected_rgb(input int x, input int y);
		if (!inside_board(x, y))
			return grid_pkg::COL_OUTSIDE;
		if ((x % grid_pkg::CELL_WIDTH < grid_pkg::LINE_WIDTH)
			|| (y % grid_pkg::CELL_HEIGHT < grid_pkg::LINE_WIDTH))
			return grid_pkg::COL_LINE;
		return status_to_colour(board[y / grid_pkg::CELL_HEIGHT][x / grid_pkg::CELL_WIDTH]);
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_rgb(input string name, input grid_pkg::rgb_t exp,
		input grid_pkg::rgb_t act);
		if (exp !== act)
		begin
			rgb_errors++;
			$display("mismatch %s: expected %03h, actual %03h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input grid_pkg::cell_status_t exp,
		input grid_pkg::cell_status_t act);
		if (exp !== act)
		begin
			status_errors++;
			$display("mismatch %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic print_counts();
		$display("Errors: rgb %0d, status %0d, other %0d", rgb_errors, status_errors,
			other_errors);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Check the oldest results, then push one raster pixel
	task automatic drive_pixel(input int x, input int y, input logic valid);
		@(negedge clk_in);
		if (st_valid[1])
		begin
			check_status(test_name, st_pipe[1], pointer_status);
		end
		if (rgb_valid[2])
		begin
			check_rgb(test_name, rgb_pipe[2], pixel_rgb);
		end
		rgb_pipe[2]  = rgb_pipe[1];
		rgb_valid[2] = rgb_valid[1];
		rgb_pipe[1]  = rgb_pipe[0];
		rgb_valid[1] = rgb_valid[0];
		st_pipe[1]   = st_pipe[0];
		st_valid[1]  = st_valid[0];
		pos_x        = grid_pkg::pos_t'(x);
		pos_y        = grid_pkg::pos_t'(y);
		rgb_pipe[0]  = expected_rgb(x, y);
		rgb_valid[0] = valid;
		// Status only defined for on-board pixels
		st_valid[0]  = valid && inside_board(x, y);
		st_pipe[0]   = grid_pkg::ST_FREE;
		if (st_valid[0])
		begin
			st_pipe[0] = board[y / grid_pkg::CELL_HEIGHT][x / grid_pkg::CELL_WIDTH];
		end
	endtask

	// Drain three stages, raster held
	task automatic flush_pixels();
		repeat (3) drive_pixel(int'(pos_x), int'(pos_y), 1'b0);
	endtask

	task automatic scan_cell(input int col, input int row);
		drive_pixel(col * grid_pkg::CELL_WIDTH + 32, row * grid_pkg::CELL_HEIGHT + 24, 1'b1);
		flush_pixels();
	endtask

	// Every cell centre, back to back
	task automatic scan_board();
		for (int row = 0; row < grid_pkg::GRID_CELLS; row++)
		begin
			for (int col = 0; col < grid_pkg::GRID_CELLS; col++)
			begin
				drive_pixel(col * grid_pkg::CELL_WIDTH + 32,
					row * grid_pkg::CELL_HEIGHT + 24, 1'b1);
			end
		end
		flush_pixels();
	endtask

	// Position first, press, hold, release, settle
	task automatic click_at(input int x, input int y, input int hold);
		@(negedge clk_in);
		mouse_pos_x = grid_pkg::pos_t'(x);
		mouse_pos_y = grid_pkg::pos_t'(y);
		mouse_click = 1'b0;
		@(negedge clk_in);
		mouse_click = 1'b1;
		repeat (hold) @(negedge clk_in);
		mouse_click = 1'b0;
		repeat (3) @(negedge clk_in);
		if (inside_board(x, y))
		begin
			board[y / grid_pkg::CELL_HEIGHT][x / grid_pkg::CELL_WIDTH] =
				advance_status(board[y / grid_pkg::CELL_HEIGHT][x / grid_pkg::CELL_WIDTH]);
		end
	endtask

	// Run limit
	always @(posedge clk_in)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			other_errors++;
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			print_counts();
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int col;
		int row;
		int x;
		int y;
		clk_in        = 1'b0;
		rst_n         = 1'b0;
		mouse_pos_x   = '0;
		mouse_pos_y   = '0;
		pos_x         = '0;
		pos_y         = '0;
		mouse_click   = 1'b0;
		rgb_errors    = 0;
		status_errors = 0;
		other_errors  = 0;
		cycle_count   = 0;
		clear_cycles  = 0;
		for (int i = 0; i < 3; i++)
		begin
			rgb_valid[i] = 1'b0;
		end
		st_valid[0] = 1'b0;
		st_valid[1] = 1'b0;
		// Model starts as the cleared board
		for (int r = 0; r < grid_pkg::GRID_CELLS; r++)
		begin
			for (int c = 0; c < grid_pkg::GRID_CELLS; c++)
			begin
				board[r][c] = grid_pkg::ST_FREE;
			end
		end

		// Reset values
		repeat (3) @(negedge clk_in);
		check_rgb("reset", grid_pkg::COL_OUTSIDE, pixel_rgb);
		check_status("reset", grid_pkg::ST_FREE, pointer_status);
		if (ready !== 1'b0)
		begin
			other_errors++;
			$display("ready is not low during reset");
		end
		rst_n = 1'b1;

		// Clear sweep
		while (ready !== 1'b1)
		begin
			@(negedge clk_in);
			clear_cycles++;
		end
		if (clear_cycles < grid_pkg::NUM_CELLS)
		begin
			other_errors++;
			$display("ready rose after %0d cycles, before the board clear ended",
				clear_cycles);
		end
		test_name = "clear_scan";
		scan_board();

		// Same cell five times, back to free
		test_name = "wrap";
		col = rand_below(grid_pkg::GRID_CELLS);
		row = rand_below(grid_pkg::GRID_CELLS);
		for (int i = 0; i < WRAP_CLICKS; i++)
		begin
			x = col * grid_pkg::CELL_WIDTH + rand_below(grid_pkg::CELL_WIDTH);
			y = row * grid_pkg::CELL_HEIGHT + rand_below(grid_pkg::CELL_HEIGHT);
			click_at(x, y, 1 + rand_below(HOLD_MAX));
			scan_cell(col, row);
		end

		// Random on-board clicks
		test_name = "random_click";
		for (int i = 0; i < RAND_CLICKS; i++)
		begin
			x = rand_below(BOARD_W);
			y = rand_below(BOARD_H);
			click_at(x, y, 1 + rand_below(HOLD_MAX));
			scan_cell(x / grid_pkg::CELL_WIDTH, y / grid_pkg::CELL_HEIGHT);
		end
		test_name = "click_scan";
		scan_board();

		// Off-board clicks leave the model alone
		test_name = "outside_click";
		for (int i = 0; i < OUTSIDE_CLICKS; i++)
		begin
			if (i % 2 == 0)
			begin
				x = BOARD_W + rand_below(1024 - BOARD_W);
				y = rand_below(1024);
			end
			else
			begin
				x = rand_below(1024);
				y = BOARD_H + rand_below(1024 - BOARD_H);
			end
			click_at(x, y, 1 + rand_below(HOLD_MAX));
		end
		// Long press counts once
		click_at(rand_below(BOARD_W), rand_below(BOARD_H), HELD_CYCLES);
		test_name = "held_scan";
		scan_board();

		// Line band and off-board pixels
		test_name = "line_outside";
		for (int i = 0; i < EDGE_PIXELS; i++)
		begin
			case (i % 3)
				0:
				begin
					x = rand_below(grid_pkg::GRID_CELLS) * grid_pkg::CELL_WIDTH
						+ rand_below(grid_pkg::LINE_WIDTH);
					y = rand_below(BOARD_H);
				end
				1:
				begin
					x = rand_below(BOARD_W);
					y = rand_below(grid_pkg::GRID_CELLS) * grid_pkg::CELL_HEIGHT
						+ rand_below(grid_pkg::LINE_WIDTH);
				end
				default:
				begin
					x = BOARD_W + rand_below(1024 - BOARD_W);
					y = rand_below(1024);
				end
			endcase
			drive_pixel(x, y, 1'b1);
		end
		flush_pixels();

		// Several pixels in flight every cycle
		test_name = "stream";
		for (int i = 0; i < STREAM_LEN; i++)
		begin
			drive_pixel(rand_below(BOARD_W + 64), rand_below(BOARD_H + 48), 1'b1);
		end
		flush_pixels();

		if (ready !== 1'b1)
		begin
			other_errors++;
			$display("ready fell after the board clear");
		end

		print_counts();
		if (rgb_errors + status_errors + other_errors == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: files.f
source/grid_pkg.sv
source/cell_loc_if.sv
source/cell_wr_if.sv
source/cell_locator.sv
source/cell_store.sv
source/grid_engine.sv
source/grid_renderer.sv
source/grid_top.sv
tb/grid_tb.sv

// File: Bender.yml
package:
  name: grid_display

sources:
  - source/grid_pkg.sv
  - source/cell_loc_if.sv
  - source/cell_wr_if.sv
  - source/cell_locator.sv
  - source/cell_store.sv
  - source/grid_engine.sv
  - source/grid_renderer.sv
  - source/grid_top.sv
  - target: test
    files:
      - tb/grid_tb.sv
